// File: chirp_capture_pkg.sv
package chirp_capture_pkg;

  // one signed i or q sample
  typedef logic signed [15:0] sample_t;

  // packed {i, q} pair
  typedef logic [31:0] iq_word_t;

  // nco phase and frequency word
  typedef logic [31:0] phase_t;

  // adc sample count, also the low global count field
  typedef logic [31:0] count_t;

  // free-running cycle counter
  typedef logic [63:0] glbl_count_t;

  // one capture output word
  typedef logic [63:0] capture_word_t;

  // source of one 32-bit capture half
  typedef enum logic [1:0] {
    ROUTE_ADC_IQ     = 2'd0,
    ROUTE_DAC_IQ     = 2'd1,
    ROUTE_ADC_COUNT  = 2'd2,
    ROUTE_GLBL_COUNT = 2'd3
  } route_sel_t;

  // chirp control states
  typedef enum logic [1:0] {
    NCO_IDLE,
    NCO_ARMED,
    NCO_RUN
  } nco_state_t;

  // dac register stages after the nco
  localparam int DAC_STAGES = 2;
  // adc and cable latency in cycles
  localparam int LOOPBACK_DELAY = 100;
  // extra words captured after enable drops
  localparam int CAPTURE_TAIL_CYCLES = 3;
  localparam int TAIL_CNT_W = $clog2(CAPTURE_TAIL_CYCLES + 1);
  // q leads i by a quarter of the sawtooth
  localparam sample_t QUARTER_TURN = 16'h4000;
  // route field positions in the control word
  localparam int ROUTE_LOWER_LSB = 0;
  localparam int ROUTE_UPPER_LSB = 4;

endpackage

// File: iq_sample_if.sv
`timescale 1ns/1ns

interface iq_sample_if;
  import chirp_capture_pkg::*;

  // dac samples, from the nco register stages
  sample_t dac_i;
  sample_t dac_q;
  // adc samples, from the loopback model
  sample_t adc_i;
  sample_t adc_q;

  // producers of the sample path
  // nco drives dac, loopback drives adc and reads dac back
  modport sample_src (
    output dac_i,
    output dac_q,
    output adc_i,
    output adc_q
  );

  // formatter reads everything
  modport sample_dst (
    input dac_i,
    input dac_q,
    input adc_i,
    input adc_q
  );

endinterface

// File: capture_ctrl_if.sv
`timescale 1ns/1ns

interface capture_ctrl_if;
  import chirp_capture_pkg::*;

  // high for every captured word
  logic        capture_en;
  // header word markers
  logic        first;
  logic        last;
  // counters for headers and count routes
  count_t      adc_count;
  glbl_count_t glbl_count;

  modport timing_src (
    output capture_en,
    output first,
    output last,
    output adc_count,
    output glbl_count
  );

  modport timing_dst (
    input capture_en,
    input first,
    input last,
    input adc_count,
    input glbl_count
  );

endinterface

// File: chirp_ramp_nco.sv
`timescale 1ns/1ns

module chirp_ramp_nco (
  input  logic                      clk_245_76MHz,
  input  logic                      cpu_reset,
  input  logic                      chirp_init_i,
  input  logic                      chirp_enable_i,
  input  chirp_capture_pkg::phase_t freq_offset_i,
  input  chirp_capture_pkg::phase_t tuning_word_coeff_i,
  input  chirp_capture_pkg::count_t count_max_i,
  output logic                      chirp_ready_o,
  output logic                      chirp_active_o,
  output logic                      chirp_done_o,
  iq_sample_if.sample_src           samples
);
  import chirp_capture_pkg::*;

  nco_state_t state;
  count_t     run_cnt;
  phase_t     phase;
  phase_t     freq;
  logic       run_last;
  sample_t    nco_i;
  sample_t    nco_q;
  sample_t    dac_i_pipe [DAC_STAGES];
  sample_t    dac_q_pipe [DAC_STAGES];

  // final active cycle, a zero count max still runs one cycle
  assign run_last = (run_cnt + count_t'(1)) >= count_max_i;

  assign chirp_ready_o  = (state == NCO_IDLE);
  assign chirp_active_o = (state == NCO_RUN);

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      state        <= NCO_IDLE;
      run_cnt      <= '0;
      phase        <= '0;
      freq         <= '0;
      chirp_done_o <= 1'b0;
    end else begin
      chirp_done_o <= 1'b0;
      case (state)
        NCO_IDLE: begin
          // arm: start frequency loaded, phase restarts at zero
          if (chirp_init_i) begin
            state <= NCO_ARMED;
            freq  <= freq_offset_i;
            phase <= '0;
          end
        end
        NCO_ARMED: begin
          run_cnt <= '0;
          if (chirp_enable_i) begin
            state <= NCO_RUN;
          end
        end
        NCO_RUN: begin
          // phase steps by freq, freq ramps by coeff
          phase   <= phase + freq;
          freq    <= freq + tuning_word_coeff_i;
          run_cnt <= run_cnt + count_t'(1);
          if (run_last) begin
            state        <= NCO_IDLE;
            chirp_done_o <= 1'b1;
          end
        end
        default: state <= NCO_IDLE;
      endcase
    end
  end

  // sawtooth straight off the phase msbs
  assign nco_i = phase[31:16];
  assign nco_q = nco_i + QUARTER_TURN;

  // dac register stages
  always_ff @(posedge clk_245_76MHz) begin
    dac_i_pipe[0] <= nco_i;
    dac_q_pipe[0] <= nco_q;
    for (int s = 1; s < DAC_STAGES; s++) begin
      dac_i_pipe[s] <= dac_i_pipe[s-1];
      dac_q_pipe[s] <= dac_q_pipe[s-1];
    end
  end

  assign samples.dac_i = dac_i_pipe[DAC_STAGES-1];
  assign samples.dac_q = dac_q_pipe[DAC_STAGES-1];

  // done only ever ends a run
  done_after_run: assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    $rose(chirp_done_o) |-> ($past(state) == NCO_RUN) && chirp_ready_o);

  ready_active_excl: assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    !(chirp_ready_o && chirp_active_o));

endmodule

// File: adc_loopback.sv
`timescale 1ns/1ns

module adc_loopback (
  input logic             clk_245_76MHz,
  input logic             cpu_reset,
  iq_sample_if.sample_src samples
);
  import chirp_capture_pkg::*;

  localparam int SAMPLE_MSB = $bits(sample_t) - 1;

  sample_t half_i;
  sample_t half_q;
  sample_t dly_i [LOOPBACK_DELAY];
  sample_t dly_q [LOOPBACK_DELAY];

  // adc sees half the dac amplitude
  // sign bit replicated so negative samples stay negative
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      half_i <= '0;
      half_q <= '0;
    end else begin
      half_i <= {samples.dac_i[SAMPLE_MSB], samples.dac_i[SAMPLE_MSB:1]};
      half_q <= {samples.dac_q[SAMPLE_MSB], samples.dac_q[SAMPLE_MSB:1]};
    end
  end

  // adc pipeline plus cable latency
  // zeros come out until the line fills after reset
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      for (int d = 0; d < LOOPBACK_DELAY; d++) begin
        dly_i[d] <= '0;
        dly_q[d] <= '0;
      end
    end else begin
      dly_i[0] <= half_i;
      dly_q[0] <= half_q;
      for (int d = 1; d < LOOPBACK_DELAY; d++) begin
        dly_i[d] <= dly_i[d-1];
        dly_q[d] <= dly_q[d-1];
      end
    end
  end

  // halving stage plus delay line gives LOOPBACK_DELAY+1 cycles
  assign samples.adc_i = dly_i[LOOPBACK_DELAY-1];
  assign samples.adc_q = dly_q[LOOPBACK_DELAY-1];

endmodule

// File: capture_timing.sv
`timescale 1ns/1ns

module capture_timing (
  input logic                clk_245_76MHz,
  input logic                cpu_reset,
  input logic                adc_enable_i,
  input logic                chirp_init_i,
  capture_ctrl_if.timing_src ctrl
);
  import chirp_capture_pkg::*;

  logic                  en_sync;
  logic                  en_fall;
  logic                  start;
  logic                  draining;
  logic [TAIL_CNT_W-1:0] tail_cnt;

  // synced enable about to drop
  assign en_fall = en_sync & ~adc_enable_i;

  // open a capture once the tail window is clear
  assign start = ~ctrl.capture_en & en_sync & (tail_cnt == '0);

  // tail ran out on a capture that is closing
  assign ctrl.last = draining & (tail_cnt == '0);

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      en_sync <= 1'b0;
    end else begin
      en_sync <= adc_enable_i;
    end
  end

  // tail latency counter also reloaded by a new chirp
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      tail_cnt <= '0;
    end else if (chirp_init_i || en_fall) begin
      tail_cnt <= TAIL_CNT_W'(CAPTURE_TAIL_CYCLES);
    end else if (tail_cnt != '0) begin
      tail_cnt <= tail_cnt - 1'b1;
    end
  end

  // capture window and header flags
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      ctrl.capture_en <= 1'b0;
      ctrl.first      <= 1'b0;
      draining        <= 1'b0;
    end else begin
      ctrl.first <= start;
      if (start) begin
        ctrl.capture_en <= 1'b1;
      end else if (ctrl.last) begin
        ctrl.capture_en <= 1'b0;
      end
      // only a live or opening capture starts draining
      if (ctrl.last) begin
        draining <= 1'b0;
      end else if (en_fall && (ctrl.capture_en || start)) begin
        draining <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      ctrl.adc_count  <= '0;
      ctrl.glbl_count <= '0;
    end else begin
      // one count per captured word
      if (ctrl.capture_en) begin
        ctrl.adc_count <= ctrl.adc_count + count_t'(1);
      end
      ctrl.glbl_count <= ctrl.glbl_count + glbl_count_t'(1);
    end
  end

  first_last_apart: assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    !(ctrl.first && ctrl.last));

  // last follows the full tail countdown and closes the window
  last_ends_capture: assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    ctrl.last |-> ($past(tail_cnt) == TAIL_CNT_W'(1)) ##1 !ctrl.capture_en);

endmodule

// File: capture_formatter.sv
`timescale 1ns/1ns

module capture_formatter (
  input  logic                             clk_245_76MHz,
  input  logic                             cpu_reset,
  input  chirp_capture_pkg::count_t        control_word_i,
  iq_sample_if.sample_dst                  samples,
  capture_ctrl_if.timing_dst               ctrl,
  output chirp_capture_pkg::capture_word_t capture_tdata_o,
  output logic                             capture_tvalid_o,
  output logic                             capture_first_o,
  output logic                             capture_last_o
);
  import chirp_capture_pkg::*;

  route_sel_t route_lower;
  route_sel_t route_upper;
  iq_word_t   adc_iq;
  iq_word_t   dac_iq;
  iq_word_t   lower_word;
  iq_word_t   upper_word;

  // one mux shared by both halves
  function automatic iq_word_t pick_half(input route_sel_t sel, input iq_word_t adc_w,
                                         input iq_word_t dac_w, input count_t adc_cnt,
                                         input glbl_count_t glbl_cnt);
    case (sel)
      ROUTE_ADC_IQ:     return adc_w;
      ROUTE_DAC_IQ:     return dac_w;
      ROUTE_ADC_COUNT:  return adc_cnt;
      ROUTE_GLBL_COUNT: return glbl_cnt[31:0];
      default:          return adc_w;
    endcase
  endfunction

  // route fields take effect one cycle after the control word
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      route_lower <= ROUTE_ADC_IQ;
      route_upper <= ROUTE_ADC_IQ;
    end else begin
      route_lower <= route_sel_t'(control_word_i[ROUTE_LOWER_LSB +: 2]);
      route_upper <= route_sel_t'(control_word_i[ROUTE_UPPER_LSB +: 2]);
    end
  end

  assign adc_iq = {samples.adc_i, samples.adc_q};
  assign dac_iq = {samples.dac_i, samples.dac_q};

  assign lower_word = pick_half(route_lower, adc_iq, dac_iq, ctrl.adc_count, ctrl.glbl_count);
  assign upper_word = pick_half(route_upper, adc_iq, dac_iq, ctrl.adc_count, ctrl.glbl_count);

  // header words carry {global count low, adc count} instead of data
  always_ff @(posedge clk_245_76MHz) begin
    if (ctrl.first || ctrl.last) begin
      capture_tdata_o <= {ctrl.glbl_count[31:0], ctrl.adc_count};
    end else begin
      capture_tdata_o <= {upper_word, lower_word};
    end
  end

  // flags lag by the same single register as the data
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      capture_tvalid_o <= 1'b0;
      capture_first_o  <= 1'b0;
      capture_last_o   <= 1'b0;
    end else begin
      capture_tvalid_o <= ctrl.capture_en;
      capture_first_o  <= ctrl.first;
      capture_last_o   <= ctrl.last;
    end
  end

endmodule

// File: chirp_capture_top.sv
`timescale 1ns/1ns

module chirp_capture_top (
  input  logic                             clk_245_76MHz,
  input  logic                             cpu_reset,
  input  logic                             chirp_init_i,
  input  logic                             chirp_enable_i,
  input  logic                             adc_enable_i,
  input  chirp_capture_pkg::count_t        chirp_control_word_i,
  input  chirp_capture_pkg::phase_t        chirp_freq_offset_i,
  input  chirp_capture_pkg::phase_t        chirp_tuning_word_coeff_i,
  input  chirp_capture_pkg::count_t        chirp_count_max_i,
  output logic                             chirp_ready_o,
  output logic                             chirp_active_o,
  output logic                             chirp_done_o,
  output chirp_capture_pkg::capture_word_t capture_tdata_o,
  output logic                             capture_tvalid_o,
  output logic                             capture_first_o,
  output logic                             capture_last_o
);

  // dac and adc samples
  iq_sample_if samples_if ();
  // capture window, flags and counters
  capture_ctrl_if ctrl_if ();

  // chirp generator feeding the dac model
  chirp_ramp_nco u_nco (
    .clk_245_76MHz       (clk_245_76MHz),
    .cpu_reset           (cpu_reset),
    .chirp_init_i        (chirp_init_i),
    .chirp_enable_i      (chirp_enable_i),
    .freq_offset_i       (chirp_freq_offset_i),
    .tuning_word_coeff_i (chirp_tuning_word_coeff_i),
    .count_max_i         (chirp_count_max_i),
    .chirp_ready_o       (chirp_ready_o),
    .chirp_active_o      (chirp_active_o),
    .chirp_done_o        (chirp_done_o),
    .samples             (samples_if.sample_src)
  );

  // dac to adc loopback
  adc_loopback u_loopback (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset     (cpu_reset),
    .samples       (samples_if.sample_src)
  );

  // runs beside the sample path
  capture_timing u_timing (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset     (cpu_reset),
    .adc_enable_i  (adc_enable_i),
    .chirp_init_i  (chirp_init_i),
    .ctrl          (ctrl_if.timing_src)
  );

  capture_formatter u_formatter (
    .clk_245_76MHz    (clk_245_76MHz),
    .cpu_reset        (cpu_reset),
    .control_word_i   (chirp_control_word_i),
    .samples          (samples_if.sample_dst),
    .ctrl             (ctrl_if.timing_dst),
    .capture_tdata_o  (capture_tdata_o),
    .capture_tvalid_o (capture_tvalid_o),
    .capture_first_o  (capture_first_o),
    .capture_last_o   (capture_last_o)
  );

endmodule

// File: tb_chirp_capture.sv
`timescale 1ns/1ns

module tb_chirp_capture;
  import chirp_capture_pkg::*;

  // cycles allowed for any wait beyond its expected length
  localparam int WAIT_LIMIT = 2000;

  logic          clk_245_76MHz;
  logic          cpu_reset;
  logic          chirp_init_i;
  logic          chirp_enable_i;
  logic          adc_enable_i;
  count_t        chirp_control_word_i;
  phase_t        chirp_freq_offset_i;
  phase_t        chirp_tuning_word_coeff_i;
  count_t        chirp_count_max_i;
  logic          chirp_ready_o;
  logic          chirp_active_o;
  logic          chirp_done_o;
  capture_word_t capture_tdata_o;
  logic          capture_tvalid_o;
  logic          capture_first_o;
  logic          capture_last_o;

  // running test name for error lines
  string       tname;
  logic [31:0] rng_state;

  // capture monitor results for the running test
  capture_word_t words [$];
  logic          first_q [$];
  logic          last_q [$];
  // chirp active at the cycle each word's dac sample left the nco
  logic          src_act_q [$];
  logic          got_last;
  int            active_cycles;
  int            done_pulses;
  logic          act_d1;
  logic          act_d2;
  logic          act_d3;

  chirp_capture_top dut (
    .clk_245_76MHz             (clk_245_76MHz),
    .cpu_reset                 (cpu_reset),
    .chirp_init_i              (chirp_init_i),
    .chirp_enable_i            (chirp_enable_i),
    .adc_enable_i              (adc_enable_i),
    .chirp_control_word_i      (chirp_control_word_i),
    .chirp_freq_offset_i       (chirp_freq_offset_i),
    .chirp_tuning_word_coeff_i (chirp_tuning_word_coeff_i),
    .chirp_count_max_i         (chirp_count_max_i),
    .chirp_ready_o             (chirp_ready_o),
    .chirp_active_o            (chirp_active_o),
    .chirp_done_o              (chirp_done_o),
    .capture_tdata_o           (capture_tdata_o),
    .capture_tvalid_o          (capture_tvalid_o),
    .capture_first_o           (capture_first_o),
    .capture_last_o            (capture_last_o)
  );

  initial begin
    clk_245_76MHz = 1'b0;
    forever #5 clk_245_76MHz = ~clk_245_76MHz;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic fail_stop(input string why);
    $display("%0s", why);
    $display("Test failures found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input string what, input capture_word_t exp,
                            input capture_word_t act);
    if (act !== exp) begin
      fail_stop($sformatf("Error: %0s %0s expected %h actual %h", tname, what, exp, act));
    end
  endtask

  task automatic check_count(input string what, input count_t exp, input count_t act);
    if (act !== exp) begin
      fail_stop($sformatf("Error: %0s %0s expected %0d actual %0d", tname, what, exp, act));
    end
  endtask

  task automatic check_sample(input string what, input sample_t exp, input sample_t act);
    if (act !== exp) begin
      fail_stop($sformatf("Error: %0s %0s expected %h actual %h", tname, what, exp, act));
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      fail_stop($sformatf("Error: %0s %0s expected %b actual %b", tname, what, exp, act));
    end
  endtask

  // inputs change 1 ns after the rising edge
  task automatic step(input int n);
    repeat (n) begin
      @(posedge clk_245_76MHz);
      #1;
    end
  endtask

  // sampled mid-cycle away from both edges
  always @(negedge clk_245_76MHz) begin
    if (!cpu_reset) begin
      if (capture_tvalid_o) begin
        words.push_back(capture_tdata_o);
        first_q.push_back(capture_first_o);
        last_q.push_back(capture_last_o);
        // two dac stages plus the formatter register
        src_act_q.push_back(act_d3);
        if (capture_last_o) begin
          got_last = 1'b1;
        end
      end
      if (chirp_active_o) begin
        active_cycles++;
      end
      if (chirp_done_o) begin
        done_pulses++;
        check_flag("ready with done", 1'b1, chirp_ready_o);
      end
    end
    act_d3 = act_d2;
    act_d2 = act_d1;
    act_d1 = chirp_active_o;
  end

  task automatic wait_ready();
    int t;
    t = 0;
    while (chirp_ready_o !== 1'b1) begin
      if (t >= WAIT_LIMIT) begin
        fail_stop($sformatf("%0s: chirp generator never became ready", tname));
      end
      step(1);
      t++;
    end
  endtask

  task automatic check_capture(input count_t cw, input phase_t coeff, input logic ramp_ok,
                               input int elen);
    int            n;
    route_sel_t    lo_sel;
    route_sel_t    up_sel;
    logic          lo_cnt;
    logic          up_cnt;
    capture_word_t w;
    capture_word_t prev;
    capture_word_t exp;
    sample_t       d2;
    sample_t       half_i;
    sample_t       half_q;
    n = words.size();
    lo_sel = route_sel_t'(cw[ROUTE_LOWER_LSB +: 2]);
    up_sel = route_sel_t'(cw[ROUTE_UPPER_LSB +: 2]);
    lo_cnt = (lo_sel == ROUTE_ADC_COUNT) || (lo_sel == ROUTE_GLBL_COUNT);
    up_cnt = (up_sel == ROUTE_ADC_COUNT) || (up_sel == ROUTE_GLBL_COUNT);
    check_count("word count", count_t'(elen + CAPTURE_TAIL_CYCLES), count_t'(n));
    for (int k = 0; k < n; k++) begin
      check_flag("first marker", k == 0, first_q[k]);
      check_flag("last marker", k == n - 1, last_q[k]);
    end
    // header words hold {global count low, adc count}
    check_count("adc count span", count_t'(n - 1), words[n-1][31:0] - words[0][31:0]);
    check_count("global count span", count_t'(n - 1), words[n-1][63:32] - words[0][63:32]);
    for (int k = 1; k < n - 1; k++) begin
      w = words[k];
      // q sits a quarter turn ahead of i
      if (lo_sel == ROUTE_DAC_IQ) begin
        check_sample("lower dac q", w[31:16] + QUARTER_TURN, w[15:0]);
      end
      if (up_sel == ROUTE_DAC_IQ) begin
        check_sample("upper dac q", w[63:48] + QUARTER_TURN, w[47:32]);
      end
      // count halves step once per word
      if (k >= 2 && (lo_cnt || up_cnt)) begin
        prev = words[k-1];
        exp = w;
        if (lo_cnt) begin
          exp[31:0] = prev[31:0] + 32'd1;
        end
        if (up_cnt) begin
          exp[63:32] = prev[63:32] + 32'd1;
        end
        check_word("count step", exp, w);
      end
      // quadratic phase gives a constant second difference while running
      if (lo_sel == ROUTE_DAC_IQ && ramp_ok && k >= 3 &&
          src_act_q[k] && src_act_q[k-1] && src_act_q[k-2]) begin
        d2 = sample_t'(w[31:16]) - sample_t'(words[k-1][31:16]) -
             sample_t'(words[k-1][31:16]) + sample_t'(words[k-2][31:16]);
        check_sample("ramp second difference", sample_t'(coeff[31:16]), d2);
      end
      // adc is half the dac LOOPBACK_DELAY+1 words later
      if (lo_sel == ROUTE_DAC_IQ && up_sel == ROUTE_ADC_IQ && k >= LOOPBACK_DELAY + 2) begin
        prev = words[k-LOOPBACK_DELAY-1];
        half_i = sample_t'(prev[31:16]) >>> 1;
        half_q = sample_t'(prev[15:0]) >>> 1;
        check_word("adc loopback", {half_i, half_q, w[31:0]}, w);
      end
    end
  endtask

  task automatic run_test(input count_t cw, input phase_t off, input phase_t coeff,
                          input count_t cmax, input int elen);
    int t;
    chirp_control_word_i = cw;
    chirp_freq_offset_i = off;
    chirp_tuning_word_coeff_i = coeff;
    chirp_count_max_i = cmax;
    // route fields register one cycle later
    step(2);
    wait_ready();
    words.delete();
    first_q.delete();
    last_q.delete();
    src_act_q.delete();
    got_last = 1'b0;
    active_cycles = 0;
    done_pulses = 0;
    chirp_init_i = 1'b1;
    step(1);
    chirp_init_i = 1'b0;
    check_flag("ready while armed", 1'b0, chirp_ready_o);
    // init reloads the tail counter so let it drain
    step(4);
    chirp_enable_i = 1'b1;
    adc_enable_i = 1'b1;
    step(1);
    chirp_enable_i = 1'b0;
    step(elen - 1);
    adc_enable_i = 1'b0;
    t = 0;
    while (!got_last) begin
      if (t >= WAIT_LIMIT) begin
        fail_stop($sformatf("%0s: capture never produced a last word", tname));
      end
      step(1);
      t++;
    end
    t = 0;
    while (done_pulses == 0) begin
      if (t >= int'(cmax) + WAIT_LIMIT) begin
        fail_stop($sformatf("%0s: chirp never signalled done", tname));
      end
      step(1);
      t++;
    end
    step(2);
    check_count("active cycles", cmax, count_t'(active_cycles));
    check_count("done cycles", count_t'(1), count_t'(done_pulses));
    check_flag("ready after done", 1'b1, chirp_ready_o);
    check_capture(cw, coeff, (off[15:0] == 16'h0) && (coeff[15:0] == 16'h0), elen);
  endtask

  initial begin
    int     fd;
    int     code;
    int     n_tests;
    int     gap;
    string  line;
    count_t cw;
    phase_t off;
    phase_t coeff;
    count_t cmax;
    int     elen;
    cpu_reset = 1'b1;
    chirp_init_i = 1'b0;
    chirp_enable_i = 1'b0;
    adc_enable_i = 1'b0;
    chirp_control_word_i = '0;
    chirp_freq_offset_i = '0;
    chirp_tuning_word_coeff_i = '0;
    chirp_count_max_i = '0;
    tname = "reset";
    got_last = 1'b0;
    active_cycles = 0;
    done_pulses = 0;
    act_d1 = 1'b0;
    act_d2 = 1'b0;
    act_d3 = 1'b0;
    rng_state = 32'hcf8f_d682;
    n_tests = 0;
    repeat (10) @(posedge clk_245_76MHz);
    #1;
    cpu_reset = 1'b0;
    step(1);
    check_flag("ready after reset", 1'b1, chirp_ready_o);
    check_flag("active after reset", 1'b0, chirp_active_o);
    check_flag("done after reset", 1'b0, chirp_done_o);
    check_flag("tvalid after reset", 1'b0, capture_tvalid_o);
    check_flag("first after reset", 1'b0, capture_first_o);
    check_flag("last after reset", 1'b0, capture_last_o);
    fd = $fopen("tb_chirp_input_vectors.txt", "r");
    if (fd == 0) begin
      fail_stop("could not open tb_chirp_input_vectors.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      code = $fgets(line, fd);
      // skip blank and comment lines
      if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
        code = $sscanf(line, "%s %h %h %h %d %d", tname, cw, off, coeff, cmax, elen);
        if (code != 6) begin
          fail_stop($sformatf("malformed vector line: %0s", line));
        end
        run_test(cw, off, coeff, cmax, elen);
        n_tests++;
        // random idle gap between tests
        rng_state = xorshift32(rng_state);
        gap = 2 + int'(rng_state % 8);
        step(gap);
      end
    end
    $fclose(fd);
    if (n_tests > 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      fail_stop("no test vectors were read");
    end
  end

endmodule

// File: tb_chirp_input_vectors.txt
# name  control_word  freq_offset  tuning_coeff  count_max  enable_len
# hex: control_word, freq_offset, tuning_coeff; decimal: count_max, enable_len
ramp_dac      00000001 00100000 00010000 200 60
loopback      00000001 01000000 00020000 300 150
count_routes  00000032 00000000 00000000 20  40
short_enable  00000011 12340000 00000000 5   1
fast_sweep    00000001 40000000 01230000 120 130
adc_lower     00000010 00800000 00040000 64  24
glbl_lower    00000023 00000000 00000000 8   12
fine_step     00000001 00123456 00000789 50  80
adc_counts    00000022 00000000 00000000 30  17
neg_ramp      00000001 f0000000 fffe0000 90  110

// File: chirp_capture_top.f
chirp_capture_pkg.sv
iq_sample_if.sv
capture_ctrl_if.sv
chirp_ramp_nco.sv
adc_loopback.sv
capture_timing.sv
capture_formatter.sv
chirp_capture_top.sv
tb_chirp_capture.sv

// File: Bender.yml
package:
  name: chirp_capture

sources:
  - chirp_capture_pkg.sv
  - iq_sample_if.sv
  - capture_ctrl_if.sv
  - chirp_ramp_nco.sv
  - adc_loopback.sv
  - capture_timing.sv
  - capture_formatter.sv
  - chirp_capture_top.sv
  - target: test
    files:
      - tb_chirp_capture.sv
